/* build.f */
+incdir+design
design/cgra_pkg.sv
design/stage_bus_if.sv
design/stage_conf_regs.sv
design/stage_mem.sv
design/stage_engine.sv
design/cgra_top.sv
test/tb_cgra.sv

/* design/cgra_cfg.svh */
`ifndef CGRA_CFG_SVH
`define CGRA_CFG_SVH

// word and host address widths
`define DATA_W 16
`define ADDR_W 10

// ring size
`define NSTAGE 4
`define NSTAGE_W 2

// 64 words of data memory per stage
`define MEM_AW 6

// local register index inside a stage
`define CONF_AW 7

// configuration register indices
`define REG_OP 0
`define REG_A_START 1
`define REG_DST_START 2
`define REG_COUNT 3

`endif

/* design/cgra_pkg.sv */
`include "cgra_cfg.svh"

package cgra_pkg;

   typedef logic [`DATA_W-1:0] data_t;

   // alu operation, two bits as written by the host
   typedef enum logic [1:0] {
      op_add,
      op_sub,
      op_and,
      op_xor
   } alu_op_t;

   typedef logic [`MEM_AW-1:0] mem_addr_t;
   typedef logic [`CONF_AW-1:0] conf_addr_t;

   // one stage's run description
   typedef struct packed {
      alu_op_t          op;
      mem_addr_t        a_start;
      mem_addr_t        dst_start;
      logic [`MEM_AW:0] count;
   } stage_conf_t;

   // one done flag per stage
   typedef logic [`NSTAGE-1:0] status_t;

endpackage

/* design/cgra_top.sv */
`timescale 1ns/1ns

`include "cgra_cfg.svh"

module cgra_top (
   input  logic                clk,
   input  logic                rst,

   // control port
   input  logic                ctr_valid,
   input  logic [`ADDR_W-1:0]  ctr_addr,
   input  logic                ctr_we,
   input  cgra_pkg::data_t     ctr_data_in,
   output cgra_pkg::data_t     ctr_data_out,

   // data port
   input  logic                data_valid,
   input  logic [`ADDR_W-3:0]  data_addr,
   input  logic                data_we,
   input  cgra_pkg::data_t     data_data_in,
   output cgra_pkg::data_t     data_data_out
);

   logic                   ctr_region;
   logic [`NSTAGE_W-1:0]   ctr_stage;
   logic [`NSTAGE_W-1:0]   data_stage;
   logic [`NSTAGE-1:0]     ctr_sel;
   logic [`NSTAGE-1:0]     data_sel;
   logic                   run_q;
   cgra_pkg::status_t      status;
   cgra_pkg::status_t      status_q;
   logic                   ctr_rd_region_q;
   logic [`NSTAGE_W-1:0]   ctr_rd_stage_q;
   logic [`NSTAGE_W-1:0]   data_rd_stage_q;
   cgra_pkg::data_t        conf_rdata [`NSTAGE];
   cgra_pkg::data_t        mem_rdata [`NSTAGE];
   cgra_pkg::data_t        flow [`NSTAGE];

   // msb picks the control region, next bits pick the stage
   assign ctr_region = ctr_addr[`ADDR_W-1];
   assign ctr_stage = ctr_addr[`ADDR_W-2 -: `NSTAGE_W];
   assign data_stage = data_addr[`ADDR_W-3 -: `NSTAGE_W];

   // per-stage strobes
   always_comb begin
      ctr_sel = '0;
      data_sel = '0;
      for (int j = 0; j < `NSTAGE; j++) begin
         if (ctr_stage == j[`NSTAGE_W-1:0]) begin
            ctr_sel[j] = ctr_valid & ~ctr_region;
         end
         if (data_stage == j[`NSTAGE_W-1:0]) begin
            data_sel[j] = data_valid;
         end
      end
   end

   // run pulse and read-return selection
   always_ff @(posedge clk) begin
      if (rst) begin
         run_q <= 1'b0;
         status_q <= '0;
         ctr_rd_region_q <= 1'b0;
         ctr_rd_stage_q <= '0;
         data_rd_stage_q <= '0;
      end else begin
         run_q <= ctr_valid & ctr_we & ctr_region & ctr_data_in[0];
         if (ctr_valid && !ctr_we) begin
            ctr_rd_region_q <= ctr_region;
            ctr_rd_stage_q <= ctr_stage;
            status_q <= status;
         end
         if (data_valid && !data_we) begin
            data_rd_stage_q <= data_stage;
         end
      end
   end

   assign ctr_data_out = ctr_rd_region_q ? cgra_pkg::data_t'(status_q)
                                         : conf_rdata[ctr_rd_stage_q];
   assign data_data_out = mem_rdata[data_rd_stage_q];

   for (genvar i = 0; i < `NSTAGE; i++) begin : g_stage
      stage_bus_if #(.addr_t(cgra_pkg::conf_addr_t)) conf_bus ();
      stage_bus_if #(.addr_t(cgra_pkg::mem_addr_t)) mem_bus ();
      cgra_pkg::stage_conf_t conf;
      cgra_pkg::mem_addr_t   eng_raddr;
      cgra_pkg::mem_addr_t   eng_waddr;
      cgra_pkg::data_t       eng_rdata;
      cgra_pkg::data_t       eng_wdata;
      logic                  eng_we;

      assign conf_bus.valid = ctr_sel[i];
      assign conf_bus.we = ctr_we;
      assign conf_bus.addr = ctr_addr[`CONF_AW-1:0];
      assign conf_bus.wdata = ctr_data_in;
      assign conf_rdata[i] = conf_bus.rdata;

      assign mem_bus.valid = data_sel[i];
      assign mem_bus.we = data_we;
      assign mem_bus.addr = data_addr[`MEM_AW-1:0];
      assign mem_bus.wdata = data_data_in;
      assign mem_rdata[i] = mem_bus.rdata;

      stage_conf_regs u_conf (
         .clk  (clk),
         .rst  (rst),
         .bus  (conf_bus.stage),
         .conf (conf)
      );

      stage_mem u_mem (
         .clk       (clk),
         .rst       (rst),
         .bus       (mem_bus.stage),
         .eng_raddr (eng_raddr),
         .eng_rdata (eng_rdata),
         .eng_we    (eng_we),
         .eng_waddr (eng_waddr),
         .eng_wdata (eng_wdata)
      );

      // previous stage feeds flow_in, stage 0 takes the last one
      stage_engine u_eng (
         .clk       (clk),
         .rst       (rst),
         .run       (run_q),
         .conf      (conf),
         .done      (status[i]),
         .mem_raddr (eng_raddr),
         .mem_rdata (eng_rdata),
         .mem_we    (eng_we),
         .mem_waddr (eng_waddr),
         .mem_wdata (eng_wdata),
         .flow_in   (flow[(i + `NSTAGE - 1) % `NSTAGE]),
         .flow_out  (flow[i])
      );
   end

endmodule

/* design/stage_bus_if.sv */
`timescale 1ns/1ns

// host access to one stage, shared by the register and memory paths
interface stage_bus_if #(
   parameter type addr_t = logic
) ();

   logic            valid;
   logic            we;
   addr_t           addr;
   cgra_pkg::data_t wdata;

   // read word, one cycle after the request
   cgra_pkg::data_t rdata;

   modport host (output valid, output we, output addr, output wdata, input rdata);

   modport stage (input valid, input we, input addr, input wdata, output rdata);

endinterface

/* design/stage_conf_regs.sv */
`timescale 1ns/1ns

`include "cgra_cfg.svh"

module stage_conf_regs (
   input  logic                  clk,
   input  logic                  rst,
   stage_bus_if.stage            bus,
   output cgra_pkg::stage_conf_t conf
);

   cgra_pkg::data_t rd_word;

   // register writes, unknown indices fall through
   always_ff @(posedge clk) begin
      if (rst) begin
         conf <= '0;
      end else if (bus.valid && bus.we) begin
         case (bus.addr)
            `REG_OP: conf.op <= cgra_pkg::alu_op_t'(bus.wdata[1:0]);
            `REG_A_START: conf.a_start <= bus.wdata[`MEM_AW-1:0];
            `REG_DST_START: conf.dst_start <= bus.wdata[`MEM_AW-1:0];
            `REG_COUNT: conf.count <= bus.wdata[`MEM_AW:0];
            default: ;
         endcase
      end
   end

   // readback word, zero extended
   always_comb begin
      rd_word = '0;
      case (bus.addr)
         `REG_OP: rd_word = cgra_pkg::data_t'(conf.op);
         `REG_A_START: rd_word = cgra_pkg::data_t'(conf.a_start);
         `REG_DST_START: rd_word = cgra_pkg::data_t'(conf.dst_start);
         `REG_COUNT: rd_word = cgra_pkg::data_t'(conf.count);
         default: rd_word = '0;
      endcase
   end

   // read data held until the next read request
   always_ff @(posedge clk) begin
      if (rst) begin
         bus.rdata <= '0;
      end else if (bus.valid && !bus.we) begin
         bus.rdata <= rd_word;
      end
   end

endmodule

/* design/stage_engine.sv */
`timescale 1ns/1ns

`include "cgra_cfg.svh"

module stage_engine (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  cgra_pkg::stage_conf_t conf,
   output logic                  done,
   output cgra_pkg::mem_addr_t   mem_raddr,
   input  cgra_pkg::data_t       mem_rdata,
   output logic                  mem_we,
   output cgra_pkg::mem_addr_t   mem_waddr,
   output cgra_pkg::data_t       mem_wdata,
   input  cgra_pkg::data_t       flow_in,
   output cgra_pkg::data_t       flow_out
);

   cgra_pkg::stage_conf_t conf_q;
   logic                  busy;
   logic [`MEM_AW:0]      iter;
   cgra_pkg::mem_addr_t   wr_off;
   cgra_pkg::data_t       alu_out;

   // iter counts engine cycles, read k in cycle k and write k in cycle k+1
   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
         iter <= '0;
      end else if (!busy) begin
         if (run && conf.count != '0) begin
            busy <= 1'b1;
            iter <= '0;
         end
      end else begin
         // last write cycle
         if (iter == conf_q.count) begin
            busy <= 1'b0;
         end
         iter <= iter + 1'b1;
      end
   end

   // settings frozen for the whole run
   always_ff @(posedge clk) begin
      if (!busy && run) begin
         conf_q <= conf;
      end
   end

   assign done = ~busy;

   // address generation
   assign wr_off = iter[`MEM_AW-1:0] - 1'b1;
   assign mem_raddr = conf_q.a_start + iter[`MEM_AW-1:0];
   assign mem_waddr = conf_q.dst_start + wr_off;
   assign mem_we = busy && (iter != '0);

   // own word goes around the ring
   assign flow_out = mem_rdata;

   // a from own memory, b from previous stage
   always_comb begin
      case (conf_q.op)
         cgra_pkg::op_sub: alu_out = mem_rdata - flow_in;
         cgra_pkg::op_and: alu_out = mem_rdata & flow_in;
         cgra_pkg::op_xor: alu_out = mem_rdata ^ flow_in;
         default: alu_out = mem_rdata + flow_in;
      endcase
   end

   assign mem_wdata = alu_out;

endmodule

/* design/stage_mem.sv */
`timescale 1ns/1ns

`include "cgra_cfg.svh"

module stage_mem (
   input  logic                clk,
   input  logic                rst,
   stage_bus_if.stage          bus,
   input  cgra_pkg::mem_addr_t eng_raddr,
   output cgra_pkg::data_t     eng_rdata,
   input  logic                eng_we,
   input  cgra_pkg::mem_addr_t eng_waddr,
   input  cgra_pkg::data_t     eng_wdata
);

   cgra_pkg::data_t mem [0:(1 << `MEM_AW)-1];

   // single write port, the engine wins
   always_ff @(posedge clk) begin
      if (eng_we) begin
         mem[eng_waddr] <= eng_wdata;
      end else if (bus.valid && bus.we) begin
         mem[bus.addr] <= bus.wdata;
      end
   end

   // engine read, registered every cycle
   always_ff @(posedge clk) begin
      eng_rdata <= mem[eng_raddr];
   end

   // host read, kept between requests
   always_ff @(posedge clk) begin
      if (rst) begin
         bus.rdata <= '0;
      end else if (bus.valid && !bus.we) begin
         bus.rdata <= mem[bus.addr];
      end
   end

endmodule

/* run.sh */
#!/bin/sh
# compile the testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cgra -f build.f -o sim_cgra
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

out=$(./obj_dir/sim_cgra)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "Simulation PASSED"; then
   exit 0
fi
exit 1

/* test/tb_cgra.sv */
`timescale 1ns/1ns

`include "cgra_cfg.svh"

module tb_cgra;

   localparam int CLK_PERIOD = 100;
   localparam int N_RUN = 4;
   // reset, config, one per memory, one per stage per run, idle stage
   localparam int N_TEST = 2 + `NSTAGE + N_RUN * `NSTAGE + 1;
   localparam int WORDS = 1 << `MEM_AW;
   localparam logic [`ADDR_W-1:0] CTRL_ADDR = 10'h200;

   logic                 clk;
   logic                 rst;
   logic                 ctr_valid;
   logic [`ADDR_W-1:0]   ctr_addr;
   logic                 ctr_we;
   cgra_pkg::data_t      ctr_data_in;
   cgra_pkg::data_t      ctr_data_out;
   logic                 data_valid;
   logic [`ADDR_W-3:0]   data_addr;
   logic                 data_we;
   cgra_pkg::data_t      data_data_in;
   cgra_pkg::data_t      data_data_out;

   integer                seed;
   int                    errors;
   int                    test_err;
   int                    n_ok;
   int                    n_bad;
   int                    cnt;
   int                    idle;
   int                    unk_st;
   int                    unk_idx;
   cgra_pkg::data_t       w;
   cgra_pkg::data_t       mem_model [`NSTAGE][WORDS];
   cgra_pkg::data_t       want [`NSTAGE][32];
   cgra_pkg::stage_conf_t conf_model [`NSTAGE];

   cgra_top dut (
      .clk           (clk),
      .rst           (rst),
      .ctr_valid     (ctr_valid),
      .ctr_addr      (ctr_addr),
      .ctr_we        (ctr_we),
      .ctr_data_in   (ctr_data_in),
      .ctr_data_out  (ctr_data_out),
      .data_valid    (data_valid),
      .data_addr     (data_addr),
      .data_we       (data_we),
      .data_data_in  (data_data_in),
      .data_data_out (data_data_out)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   initial begin
      #((N_TEST * (64 + 20) + 200) * CLK_PERIOD);
      $display("timeout: the tests did not finish in the expected time");
      $display("Simulation FAILED");
      $finish;
   end

   function automatic int pick_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic logic [`ADDR_W-1:0] conf_addr(input int st, input int idx);
      return {1'b0, st[`NSTAGE_W-1:0], idx[`CONF_AW-1:0]};
   endfunction

   // expected register readback with fields zero extended
   function automatic cgra_pkg::data_t reg_value(input int st, input int idx);
      case (idx)
         `REG_OP: return cgra_pkg::data_t'(conf_model[st].op);
         `REG_A_START: return cgra_pkg::data_t'(conf_model[st].a_start);
         `REG_DST_START: return cgra_pkg::data_t'(conf_model[st].dst_start);
         `REG_COUNT: return cgra_pkg::data_t'(conf_model[st].count);
         default: return '0;
      endcase
   endfunction

   function automatic cgra_pkg::data_t alu_model(input cgra_pkg::alu_op_t op,
                                                 input cgra_pkg::data_t a,
                                                 input cgra_pkg::data_t b);
      case (op)
         cgra_pkg::op_add: return a + b;
         cgra_pkg::op_sub: return a - b;
         cgra_pkg::op_and: return a & b;
         default: return a ^ b;
      endcase
   endfunction

   task automatic check_word(input string name, input cgra_pkg::data_t expected,
                             input cgra_pkg::data_t actual);
      if (expected !== actual) begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_status(input string name, input cgra_pkg::status_t expected,
                               input cgra_pkg::status_t actual);
      if (expected !== actual) begin
         errors++;
         $display("[ERROR] %s: expected status %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic end_test(input string name);
      if (errors == test_err) begin
         n_ok++;
         $display("test %s: ok", name);
      end else begin
         n_bad++;
         $display("test %s: %0d mismatches", name, errors - test_err);
      end
   endtask

   // bus tasks start on a falling edge and return on the next one
   task automatic ctr_write(input logic [`ADDR_W-1:0] addr, input cgra_pkg::data_t wdata);
      ctr_valid = 1'b1;
      ctr_we = 1'b1;
      ctr_addr = addr;
      ctr_data_in = wdata;
      @(negedge clk);
      ctr_valid = 1'b0;
   endtask

   task automatic ctr_read(input logic [`ADDR_W-1:0] addr, output cgra_pkg::data_t rdata);
      ctr_valid = 1'b1;
      ctr_we = 1'b0;
      ctr_addr = addr;
      @(negedge clk);
      rdata = ctr_data_out;
      ctr_valid = 1'b0;
   endtask

   task automatic mem_write(input int st, input int addr, input cgra_pkg::data_t wdata);
      data_valid = 1'b1;
      data_we = 1'b1;
      data_addr = {st[`NSTAGE_W-1:0], addr[`MEM_AW-1:0]};
      data_data_in = wdata;
      @(negedge clk);
      data_valid = 1'b0;
   endtask

   task automatic mem_read(input int st, input int addr, output cgra_pkg::data_t rdata);
      data_valid = 1'b1;
      data_we = 1'b0;
      data_addr = {st[`NSTAGE_W-1:0], addr[`MEM_AW-1:0]};
      @(negedge clk);
      rdata = data_data_out;
      data_valid = 1'b0;
   endtask

   // register write that keeps the model in step with fields masked to width
   task automatic set_conf(input int st, input int idx, input cgra_pkg::data_t wdata);
      ctr_write(conf_addr(st, idx), wdata);
      case (idx)
         `REG_OP: conf_model[st].op = cgra_pkg::alu_op_t'(wdata[1:0]);
         `REG_A_START: conf_model[st].a_start = wdata[`MEM_AW-1:0];
         `REG_DST_START: conf_model[st].dst_start = wdata[`MEM_AW-1:0];
         `REG_COUNT: conf_model[st].count = wdata[`MEM_AW:0];
         default: ;
      endcase
   endtask

   // random run setup with sources in the lower half and results in the upper half
   task automatic setup_run(input int idle_st);
      int prev;
      cnt = 1 + pick_below(32);
      for (int s = 0; s < `NSTAGE; s++) begin
         set_conf(s, `REG_OP, cgra_pkg::data_t'(pick_below(4)));
         set_conf(s, `REG_A_START, cgra_pkg::data_t'(pick_below(33 - cnt)));
         set_conf(s, `REG_DST_START, cgra_pkg::data_t'(32 + pick_below(33 - cnt)));
         set_conf(s, `REG_COUNT, (s == idle_st) ? 16'h0000 : cgra_pkg::data_t'(cnt));
      end
      for (int s = 0; s < `NSTAGE; s++) begin
         prev = (s + `NSTAGE - 1) % `NSTAGE;
         for (int k = 0; k < cnt; k++) begin
            want[s][k] = alu_model(conf_model[s].op,
                                   mem_model[s][conf_model[s].a_start + k],
                                   mem_model[prev][conf_model[prev].a_start + k]);
         end
      end
   endtask

   // start and pulse again while busy then poll until every stage is done
   task automatic run_and_wait(input string name, input cgra_pkg::status_t busy_exp);
      cgra_pkg::data_t rd;
      ctr_write(CTRL_ADDR, 16'h0001);
      ctr_write(CTRL_ADDR, 16'h0001);
      ctr_read(CTRL_ADDR, rd);
      check_status({name, " busy flags"}, busy_exp, cgra_pkg::status_t'(rd));
      do begin
         ctr_read(CTRL_ADDR, rd);
      end while (cgra_pkg::status_t'(rd) != '1);
   endtask

   task automatic check_results(input string name, input int st);
      cgra_pkg::data_t rd;
      for (int k = 0; k < cnt; k++) begin
         mem_read(st, conf_model[st].dst_start + k, rd);
         check_word(name, want[st][k], rd);
         mem_model[st][conf_model[st].dst_start + k] = want[st][k];
      end
   endtask

   initial begin
      seed = 32'h5204_4296;
      errors = 0;
      n_ok = 0;
      n_bad = 0;
      rst = 1'b1;
      ctr_valid = 1'b0;
      ctr_addr = '0;
      ctr_we = 1'b0;
      ctr_data_in = '0;
      data_valid = 1'b0;
      data_addr = '0;
      data_we = 1'b0;
      data_data_in = '0;
      for (int s = 0; s < `NSTAGE; s++) begin
         conf_model[s] = '0;
      end
      repeat (5) @(negedge clk);
      rst = 1'b0;

      test_err = errors;
      check_word("reset ctr_data_out", '0, ctr_data_out);
      check_word("reset data_data_out", '0, data_data_out);
      ctr_read(CTRL_ADDR, w);
      check_status("reset status", '1, cgra_pkg::status_t'(w));
      for (int s = 0; s < `NSTAGE; s++) begin
         for (int i = 0; i < 4; i++) begin
            ctr_read(conf_addr(s, i), w);
            check_word($sformatf("reset reg %0d.%0d", s, i), '0, w);
         end
      end
      end_test("reset");

      // distinct random values in every stage expose writes to the wrong stage
      test_err = errors;
      for (int s = 0; s < `NSTAGE; s++) begin
         for (int i = 0; i < 4; i++) begin
            set_conf(s, i, cgra_pkg::data_t'($random(seed)));
         end
      end
      // unknown index written once and read back in every stage
      unk_st = pick_below(`NSTAGE);
      unk_idx = 4 + pick_below(124);
      ctr_write(conf_addr(unk_st, unk_idx), 16'hffff);
      for (int s = 0; s < `NSTAGE; s++) begin
         for (int i = 0; i < 4; i++) begin
            ctr_read(conf_addr(s, i), w);
            check_word($sformatf("config reg %0d.%0d", s, i), reg_value(s, i), w);
         end
         ctr_read(conf_addr(s, unk_idx), w);
         check_word($sformatf("config unknown reg %0d.%0d", s, unk_idx), '0, w);
      end
      end_test("config registers");

      for (int s = 0; s < `NSTAGE; s++) begin
         for (int a = 0; a < WORDS; a++) begin
            mem_model[s][a] = cgra_pkg::data_t'($random(seed));
            mem_write(s, a, mem_model[s][a]);
         end
      end
      for (int s = 0; s < `NSTAGE; s++) begin
         test_err = errors;
         for (int a = 0; a < WORDS; a++) begin
            mem_read(s, a, w);
            check_word($sformatf("memory %0d word %0d", s, a), mem_model[s][a], w);
         end
         end_test($sformatf("memory %0d", s));
      end

      for (int r = 0; r < N_RUN; r++) begin
         test_err = errors;
         setup_run(-1);
         run_and_wait($sformatf("run %0d", r), '0);
         for (int s = 0; s < `NSTAGE; s++) begin
            check_results($sformatf("run %0d stage %0d", r, s), s);
            end_test($sformatf("run %0d stage %0d", r, s));
            test_err = errors;
         end
      end

      test_err = errors;
      idle = pick_below(`NSTAGE);
      setup_run(idle);
      run_and_wait("idle stage", cgra_pkg::status_t'(1 << idle));
      for (int a = 0; a < WORDS; a++) begin
         mem_read(idle, a, w);
         check_word($sformatf("idle memory word %0d", a), mem_model[idle][a], w);
      end
      // the stage after the idle one combines with a word that does not step
      for (int s = 0; s < `NSTAGE; s++) begin
         if (s != idle && s != (idle + 1) % `NSTAGE) begin
            check_results($sformatf("idle run stage %0d", s), s);
         end
      end
      end_test("idle stage");

      $display("tests: %0d ok, %0d with errors, %0d mismatches in total",
               n_ok, n_bad, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule
